//--- hdl/csr_pkg.sv
package csr_pkg;

    localparam int data_w     = 32;
    localparam int csr_num_w  = 14;
    localparam int num_hw_int = 8;

    // implemented register numbers
    typedef enum logic [csr_num_w-1:0] {
        crmd   = 14'h000,
        prmd   = 14'h001,
        ecfg   = 14'h004,
        estat  = 14'h005,
        era    = 14'h006,
        badv   = 14'h007,
        eentry = 14'h00c,
        save0  = 14'h030,
        tid    = 14'h040,
        tcfg   = 14'h041,
        tval   = 14'h042,
        ticlr  = 14'h044
    } csr_num_e;

    // primary exception codes
    typedef enum logic [5:0] {
        intr = 6'h00,
        ade  = 6'h08,
        ale  = 6'h09,
        sys  = 6'h0b,
        brk  = 6'h0c,
        ine  = 6'h0d
    } ecode_e;

    localparam logic [8:0] esubcode_adef = 9'd0;
    localparam logic [8:0] esubcode_adem = 9'd1;

    // crmd fields
    localparam int crmd_plv_lo  = 0;
    localparam int crmd_plv_w   = 2;
    localparam int crmd_ie_lo   = 2;
    localparam int crmd_ie_w    = 1;
    localparam int crmd_da_lo   = 3;
    localparam int crmd_da_w    = 1;
    localparam int crmd_pg_lo   = 4;
    localparam int crmd_pg_w    = 1;
    localparam int crmd_datf_lo = 5;
    localparam int crmd_datf_w  = 2;
    localparam int crmd_datm_lo = 7;
    localparam int crmd_datm_w  = 2;

    // prmd fields
    localparam int prmd_pplv_lo = 0;
    localparam int prmd_pplv_w  = 2;
    localparam int prmd_pie_lo  = 2;
    localparam int prmd_pie_w   = 1;

    // ecfg, bit 10 of lie has no interrupt source
    localparam int ecfg_lie_lo   = 0;
    localparam int ecfg_lie_w    = 13;
    localparam int ecfg_rsvd_bit = 10;

    // estat fields
    localparam int estat_is_lo       = 0;
    localparam int estat_is_w        = 13;
    localparam int estat_sw_lo       = 0;
    localparam int estat_sw_w        = 2;
    localparam int estat_hw_lo       = 2;
    localparam int estat_hw_w        = num_hw_int;
    localparam int estat_ti_bit      = 11;
    localparam int estat_ipi_bit     = 12;
    localparam int estat_ecode_lo    = 16;
    localparam int estat_ecode_w     = 6;
    localparam int estat_esubcode_lo = 22;
    localparam int estat_esubcode_w  = 9;

    localparam int eentry_va_lo = 6;
    localparam int eentry_va_w  = 26;

    // timer fields
    localparam int tcfg_en_lo       = 0;
    localparam int tcfg_periodic_lo = 1;
    localparam int tcfg_initval_lo  = 2;
    localparam int tcfg_initval_w   = 30;
    localparam int ticlr_clr_lo     = 0;

endpackage

//--- hdl/csr_mode_regs.sv
module csr_mode_regs (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [csr_pkg::csr_num_w-1:0] csr_num,
    input  logic                          csr_we,
    input  logic [csr_pkg::data_w-1:0]    csr_wmask,
    input  logic [csr_pkg::data_w-1:0]    csr_wvalue,
    input  logic                          wb_ex,
    input  logic                          ertn_flush,
    output logic                          crmd_ie,
    output logic [csr_pkg::data_w-1:0]    rvalue
);

    logic [1:0]                plv;
    logic                      da;
    logic                      pg;
    logic [1:0]                datf;
    logic [1:0]                datm;
    logic [1:0]                pplv;
    logic                      pie;
    logic                      crmd_wr;
    logic                      prmd_wr;
    logic [csr_pkg::data_w-1:0] merged;

    assign crmd_wr = csr_we && (csr_num == csr_pkg::crmd);
    assign prmd_wr = csr_we && (csr_num == csr_pkg::prmd);

    always_comb
    begin
        rvalue = '0;
        if (csr_num == csr_pkg::crmd)
        begin
            rvalue[csr_pkg::crmd_plv_lo +: csr_pkg::crmd_plv_w]   = plv;
            rvalue[csr_pkg::crmd_ie_lo +: csr_pkg::crmd_ie_w]     = crmd_ie;
            rvalue[csr_pkg::crmd_da_lo +: csr_pkg::crmd_da_w]     = da;
            rvalue[csr_pkg::crmd_pg_lo +: csr_pkg::crmd_pg_w]     = pg;
            rvalue[csr_pkg::crmd_datf_lo +: csr_pkg::crmd_datf_w] = datf;
            rvalue[csr_pkg::crmd_datm_lo +: csr_pkg::crmd_datm_w] = datm;
        end
        else if (csr_num == csr_pkg::prmd)
        begin
            rvalue[csr_pkg::prmd_pplv_lo +: csr_pkg::prmd_pplv_w] = pplv;
            rvalue[csr_pkg::prmd_pie_lo +: csr_pkg::prmd_pie_w]   = pie;
        end
    end

    // old contents of the selected register fill the unmasked bits
    assign merged = (csr_wmask & csr_wvalue) | (~csr_wmask & rvalue);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            plv     <= 2'b00;
            crmd_ie <= 1'b0;
            da      <= 1'b1;
            pg      <= 1'b0;
            datf    <= 2'b00;
            datm    <= 2'b00;
        end
        else
        begin
            // exception entry drops to kernel with interrupts masked
            if (wb_ex)
            begin
                plv     <= 2'b00;
                crmd_ie <= 1'b0;
            end
            else if (ertn_flush)
            begin
                plv     <= pplv;
                crmd_ie <= pie;
            end
            else if (crmd_wr)
            begin
                plv     <= merged[csr_pkg::crmd_plv_lo +: csr_pkg::crmd_plv_w];
                crmd_ie <= merged[csr_pkg::crmd_ie_lo +: csr_pkg::crmd_ie_w];
            end
            if (crmd_wr)
            begin
                da   <= merged[csr_pkg::crmd_da_lo +: csr_pkg::crmd_da_w];
                pg   <= merged[csr_pkg::crmd_pg_lo +: csr_pkg::crmd_pg_w];
                datf <= merged[csr_pkg::crmd_datf_lo +: csr_pkg::crmd_datf_w];
                datm <= merged[csr_pkg::crmd_datm_lo +: csr_pkg::crmd_datm_w];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pplv <= 2'b00;
            pie  <= 1'b0;
        end
        else if (wb_ex)
        begin
            pplv <= plv;
            pie  <= crmd_ie;
        end
        else if (prmd_wr)
        begin
            pplv <= merged[csr_pkg::prmd_pplv_lo +: csr_pkg::prmd_pplv_w];
            pie  <= merged[csr_pkg::prmd_pie_lo +: csr_pkg::prmd_pie_w];
        end
    end

endmodule

//--- hdl/csr_exc_regs.sv
module csr_exc_regs (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [csr_pkg::csr_num_w-1:0]  csr_num,
    input  logic                           csr_we,
    input  logic [csr_pkg::data_w-1:0]     csr_wmask,
    input  logic [csr_pkg::data_w-1:0]     csr_wvalue,
    input  logic                           wb_ex,
    input  logic [csr_pkg::data_w-1:0]     wb_pc,
    input  logic [5:0]                     wb_ecode,
    input  logic [8:0]                     wb_esubcode,
    input  logic [csr_pkg::data_w-1:0]     wb_vaddr,
    input  logic [csr_pkg::num_hw_int-1:0] hw_int_in,
    input  logic                           ipi_int_in,
    input  logic                           ti_pending,
    input  logic                           crmd_ie,
    output logic [csr_pkg::data_w-1:0]     era,
    output logic [csr_pkg::data_w-1:0]     ex_entry,
    output logic                           has_int,
    output logic [5:0]                     stat_ecode,
    output logic [csr_pkg::data_w-1:0]     rvalue
);

    localparam logic [csr_pkg::ecfg_lie_w-1:0] lie_rsvd =
        csr_pkg::ecfg_lie_w'(1) << csr_pkg::ecfg_rsvd_bit;

    logic [csr_pkg::ecfg_lie_w-1:0]     lie;
    logic [csr_pkg::estat_sw_w-1:0]     is_sw;
    logic [csr_pkg::estat_hw_w-1:0]     is_hw;
    logic                               is_ipi;
    logic [csr_pkg::estat_is_w-1:0]     is_vec;
    logic [8:0]                         esubcode;
    logic [csr_pkg::data_w-1:0]         badv;
    logic [csr_pkg::eentry_va_w-1:0]    eentry_va;
    logic [csr_pkg::data_w-1:0]         merged;
    logic                               badv_load;
    logic                               badv_from_pc;

    // interrupt status with bit 10 always zero
    always_comb
    begin
        is_vec = '0;
        is_vec[csr_pkg::estat_sw_lo +: csr_pkg::estat_sw_w] = is_sw;
        is_vec[csr_pkg::estat_hw_lo +: csr_pkg::estat_hw_w] = is_hw;
        is_vec[csr_pkg::estat_ti_bit]  = ti_pending;
        is_vec[csr_pkg::estat_ipi_bit] = is_ipi;
    end

    always_comb
    begin
        ex_entry = '0;
        ex_entry[csr_pkg::eentry_va_lo +: csr_pkg::eentry_va_w] = eentry_va;
    end

    always_comb
    begin
        rvalue = '0;
        case (csr_num)
            csr_pkg::ecfg:
                rvalue[csr_pkg::ecfg_lie_lo +: csr_pkg::ecfg_lie_w] = lie;
            csr_pkg::estat:
            begin
                rvalue[csr_pkg::estat_is_lo +: csr_pkg::estat_is_w]       = is_vec;
                rvalue[csr_pkg::estat_ecode_lo +: csr_pkg::estat_ecode_w] = stat_ecode;
                rvalue[csr_pkg::estat_esubcode_lo +: csr_pkg::estat_esubcode_w] = esubcode;
            end
            csr_pkg::era:    rvalue = era;
            csr_pkg::badv:   rvalue = badv;
            csr_pkg::eentry: rvalue = ex_entry;
            default:         rvalue = '0;
        endcase
    end

    assign merged = (csr_wmask & csr_wvalue) | (~csr_wmask & rvalue);

    assign has_int = ((is_vec[11:0] & lie[11:0]) != 12'b0) && crmd_ie;

    always_ff @(posedge clk)
    begin
        if (reset)
            lie <= '0;
        else if (csr_we && (csr_num == csr_pkg::ecfg))
            lie <= merged[csr_pkg::ecfg_lie_lo +: csr_pkg::ecfg_lie_w] & ~lie_rsvd;
    end

    // hardware and inter-core lines sampled every cycle
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            is_sw  <= '0;
            is_hw  <= '0;
            is_ipi <= 1'b0;
        end
        else
        begin
            is_hw  <= hw_int_in;
            is_ipi <= ipi_int_in;
            if (csr_we && (csr_num == csr_pkg::estat))
                is_sw <= merged[csr_pkg::estat_sw_lo +: csr_pkg::estat_sw_w];
        end
    end

    // only address faults record a bad address
    assign badv_load    = wb_ex && ((wb_ecode == csr_pkg::ade) || (wb_ecode == csr_pkg::ale));
    assign badv_from_pc = (wb_ecode == csr_pkg::ade) && (wb_esubcode == csr_pkg::esubcode_adef);

    always_ff @(posedge clk)
    begin
        if (wb_ex)
        begin
            stat_ecode <= wb_ecode;
            esubcode   <= wb_esubcode;
            era        <= wb_pc;
        end
        else if (csr_we && (csr_num == csr_pkg::era))
            era <= merged;

        if (badv_load)
            badv <= badv_from_pc ? wb_pc : wb_vaddr;
        else if (csr_we && (csr_num == csr_pkg::badv))
            badv <= merged;

        if (csr_we && (csr_num == csr_pkg::eentry))
            eentry_va <= merged[csr_pkg::eentry_va_lo +: csr_pkg::eentry_va_w];
    end

endmodule

//--- hdl/csr_save_regs.sv
module csr_save_regs #(
    parameter int num_save_regs = 4
) (
    input  logic                          clk,
    input  logic [csr_pkg::csr_num_w-1:0] csr_num,
    input  logic                          csr_we,
    input  logic [csr_pkg::data_w-1:0]    csr_wmask,
    input  logic [csr_pkg::data_w-1:0]    csr_wvalue,
    output logic [csr_pkg::data_w-1:0]    rvalue
);

    logic [csr_pkg::data_w-1:0]    save_q [num_save_regs];
    logic [csr_pkg::csr_num_w-1:0] offset;
    logic [csr_pkg::data_w-1:0]    merged;

    // numbers below save0 wrap to large offsets and miss
    assign offset = csr_num - csr_pkg::save0;

    always_comb
    begin
        rvalue = '0;
        for (int i = 0; i < num_save_regs; i++)
        begin
            if (offset == csr_pkg::csr_num_w'(i))
                rvalue = save_q[i];
        end
    end

    assign merged = (csr_wmask & csr_wvalue) | (~csr_wmask & rvalue);

    always_ff @(posedge clk)
    begin
        for (int i = 0; i < num_save_regs; i++)
        begin
            if (csr_we && (offset == csr_pkg::csr_num_w'(i)))
                save_q[i] <= merged;
        end
    end

endmodule

//--- hdl/csr_timer.sv
module csr_timer (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [csr_pkg::csr_num_w-1:0] csr_num,
    input  logic                          csr_we,
    input  logic [csr_pkg::data_w-1:0]    csr_wmask,
    input  logic [csr_pkg::data_w-1:0]    csr_wvalue,
    input  logic [csr_pkg::data_w-1:0]    coreid_in,
    output logic                          ti_pending,
    output logic [csr_pkg::data_w-1:0]    rvalue
);

    logic [csr_pkg::data_w-1:0]         tid_q;
    logic                               tcfg_en;
    logic                               tcfg_periodic;
    logic [csr_pkg::tcfg_initval_w-1:0] tcfg_initval;
    logic [csr_pkg::data_w-1:0]         tcfg_word;
    logic [csr_pkg::data_w-1:0]         cnt;
    logic [csr_pkg::data_w-1:0]         merged;
    logic                               tcfg_wr;
    logic                               ticlr_clr;

    always_comb
    begin
        tcfg_word = '0;
        tcfg_word[csr_pkg::tcfg_en_lo]       = tcfg_en;
        tcfg_word[csr_pkg::tcfg_periodic_lo] = tcfg_periodic;
        tcfg_word[csr_pkg::tcfg_initval_lo +: csr_pkg::tcfg_initval_w] = tcfg_initval;
    end

    // ticlr falls to the default and reads as zero
    always_comb
    begin
        case (csr_num)
            csr_pkg::tid:  rvalue = tid_q;
            csr_pkg::tcfg: rvalue = tcfg_word;
            csr_pkg::tval: rvalue = cnt;
            default:       rvalue = '0;
        endcase
    end

    assign merged    = (csr_wmask & csr_wvalue) | (~csr_wmask & rvalue);
    assign tcfg_wr   = csr_we && (csr_num == csr_pkg::tcfg);
    assign ticlr_clr = csr_we && (csr_num == csr_pkg::ticlr)
                       && csr_wmask[csr_pkg::ticlr_clr_lo] && csr_wvalue[csr_pkg::ticlr_clr_lo];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            tid_q   <= coreid_in;
            tcfg_en <= 1'b0;
        end
        else
        begin
            if (csr_we && (csr_num == csr_pkg::tid))
                tid_q <= merged;
            if (tcfg_wr)
                tcfg_en <= merged[csr_pkg::tcfg_en_lo];
        end
    end

    always_ff @(posedge clk)
    begin
        if (tcfg_wr)
        begin
            tcfg_periodic <= merged[csr_pkg::tcfg_periodic_lo];
            tcfg_initval  <= merged[csr_pkg::tcfg_initval_lo +: csr_pkg::tcfg_initval_w];
        end
    end

    // countdown stops at all ones in one-shot mode
    always_ff @(posedge clk)
    begin
        if (reset)
            cnt <= '1;
        else if (tcfg_wr && merged[csr_pkg::tcfg_en_lo])
            cnt <= {merged[csr_pkg::tcfg_initval_lo +: csr_pkg::tcfg_initval_w], 2'b00};
        else if (tcfg_en && (cnt != '1))
        begin
            if ((cnt == '0) && tcfg_periodic)
                cnt <= {tcfg_initval, 2'b00};
            else
                cnt <= cnt - 1'b1;
        end
    end

    // set wins over a clear in the same cycle
    always_ff @(posedge clk)
    begin
        if (reset)
            ti_pending <= 1'b0;
        else if (cnt == '0)
            ti_pending <= 1'b1;
        else if (ticlr_clr)
            ti_pending <= 1'b0;
    end

endmodule

//--- hdl/csr_file.sv
module csr_file #(
    parameter int num_save_regs = 4
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [csr_pkg::csr_num_w-1:0]  csr_num,
    input  logic                           csr_re,
    input  logic                           csr_we,
    input  logic [csr_pkg::data_w-1:0]     csr_wmask,
    input  logic [csr_pkg::data_w-1:0]     csr_wvalue,
    input  logic                           wb_ex,
    input  logic [csr_pkg::data_w-1:0]     wb_pc,
    input  logic [5:0]                     wb_ecode,
    input  logic [8:0]                     wb_esubcode,
    input  logic [csr_pkg::data_w-1:0]     wb_vaddr,
    input  logic                           ertn_flush,
    input  logic [csr_pkg::num_hw_int-1:0] hw_int_in,
    input  logic                           ipi_int_in,
    input  logic [csr_pkg::data_w-1:0]     coreid_in,
    output logic [csr_pkg::data_w-1:0]     csr_rvalue,
    output logic [csr_pkg::data_w-1:0]     ertn_pc,
    output logic [csr_pkg::data_w-1:0]     ex_entry,
    output logic                           has_int,
    output logic [5:0]                     stat_ecode
);

    logic                       crmd_ie;
    logic                       ti_pending;
    logic [csr_pkg::data_w-1:0] mode_rvalue;
    logic [csr_pkg::data_w-1:0] exc_rvalue;
    logic [csr_pkg::data_w-1:0] save_rvalue;
    logic [csr_pkg::data_w-1:0] timer_rvalue;

    // reads are always live, csr_re is only for the pipeline
    csr_mode_regs i_mode_regs (
        .clk        (clk),
        .reset      (reset),
        .csr_num    (csr_num),
        .csr_we     (csr_we),
        .csr_wmask  (csr_wmask),
        .csr_wvalue (csr_wvalue),
        .wb_ex      (wb_ex),
        .ertn_flush (ertn_flush),
        .crmd_ie    (crmd_ie),
        .rvalue     (mode_rvalue)
    );

    csr_exc_regs i_exc_regs (
        .clk         (clk),
        .reset       (reset),
        .csr_num     (csr_num),
        .csr_we      (csr_we),
        .csr_wmask   (csr_wmask),
        .csr_wvalue  (csr_wvalue),
        .wb_ex       (wb_ex),
        .wb_pc       (wb_pc),
        .wb_ecode    (wb_ecode),
        .wb_esubcode (wb_esubcode),
        .wb_vaddr    (wb_vaddr),
        .hw_int_in   (hw_int_in),
        .ipi_int_in  (ipi_int_in),
        .ti_pending  (ti_pending),
        .crmd_ie     (crmd_ie),
        .era         (ertn_pc),
        .ex_entry    (ex_entry),
        .has_int     (has_int),
        .stat_ecode  (stat_ecode),
        .rvalue      (exc_rvalue)
    );

    csr_save_regs #(
        .num_save_regs (num_save_regs)
    ) i_save_regs (
        .clk        (clk),
        .csr_num    (csr_num),
        .csr_we     (csr_we),
        .csr_wmask  (csr_wmask),
        .csr_wvalue (csr_wvalue),
        .rvalue     (save_rvalue)
    );

    csr_timer i_timer (
        .clk        (clk),
        .reset      (reset),
        .csr_num    (csr_num),
        .csr_we     (csr_we),
        .csr_wmask  (csr_wmask),
        .csr_wvalue (csr_wvalue),
        .coreid_in  (coreid_in),
        .ti_pending (ti_pending),
        .rvalue     (timer_rvalue)
    );

    // each block returns zero unless csr_num is one of its own
    assign csr_rvalue = mode_rvalue | exc_rvalue | save_rvalue | timer_rvalue;

endmodule

//--- test/tb_clock_gen.sv
module tb_clock_gen #(
    parameter int period_ns = 40
) (
    output logic clk
);

    timeunit 1ns;
    timeprecision 1ps;

    initial
    begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

endmodule

//--- test/csr_file_assertions.sv
module csr_file_assertions (
    input logic       clk,
    input logic       reset,
    input logic       wb_ex,
    input logic       ertn_flush,
    input logic [1:0] plv,
    input logic       crmd_ie,
    input logic [1:0] pplv
);

    timeunit 1ns;
    timeprecision 1ps;

    // exception entry drops to kernel with interrupts masked
    exc_entry_clears_mode: assert property (
        @(posedge clk) disable iff (reset)
        wb_ex |=> ((plv == 2'b00) && !crmd_ie)
    ) else $error("plv or ie still set in the cycle after exception entry");

    // return takes the saved privilege level
    ertn_restores_plv: assert property (
        @(posedge clk) disable iff (reset)
        (ertn_flush && !wb_ex) |=> (plv == $past(pplv))
    ) else $error("plv does not match the saved pplv after return");

endmodule

bind csr_mode_regs csr_file_assertions i_mode_assertions (
    .clk        (clk),
    .reset      (reset),
    .wb_ex      (wb_ex),
    .ertn_flush (ertn_flush),
    .plv        (plv),
    .crmd_ie    (crmd_ie),
    .pplv       (pplv)
);

//--- test/tb_csr_file.sv
module tb_csr_file;

    timeunit 1ns;
    timeprecision 1ps;

    logic                           clk;
    logic                           reset;
    logic [csr_pkg::csr_num_w-1:0]  csr_num;
    logic                           csr_re;
    logic                           csr_we;
    logic [31:0]                    csr_wmask;
    logic [31:0]                    csr_wvalue;
    logic                           wb_ex;
    logic [31:0]                    wb_pc;
    logic [5:0]                     wb_ecode;
    logic [8:0]                     wb_esubcode;
    logic [31:0]                    wb_vaddr;
    logic                           ertn_flush;
    logic [csr_pkg::num_hw_int-1:0] hw_int_in;
    logic                           ipi_int_in;
    logic [31:0]                    coreid_in;
    logic [31:0]                    csr_rvalue;
    logic [31:0]                    ertn_pc;
    logic [31:0]                    ex_entry;
    logic                           has_int;
    logic [5:0]                     stat_ecode;

    int          error_count;
    int          timeout_count;
    logic [31:0] lcg_state;
    logic [31:0] save_model [4];

    tb_clock_gen #(.period_ns(40)) i_clock_gen (.clk(clk));

    csr_file #(.num_save_regs(4)) i_csr_file (
        .clk         (clk),
        .reset       (reset),
        .csr_num     (csr_num),
        .csr_re      (csr_re),
        .csr_we      (csr_we),
        .csr_wmask   (csr_wmask),
        .csr_wvalue  (csr_wvalue),
        .wb_ex       (wb_ex),
        .wb_pc       (wb_pc),
        .wb_ecode    (wb_ecode),
        .wb_esubcode (wb_esubcode),
        .wb_vaddr    (wb_vaddr),
        .ertn_flush  (ertn_flush),
        .hw_int_in   (hw_int_in),
        .ipi_int_in  (ipi_int_in),
        .coreid_in   (coreid_in),
        .csr_rvalue  (csr_rvalue),
        .ertn_pc     (ertn_pc),
        .ex_entry    (ex_entry),
        .has_int     (has_int),
        .stat_ecode  (stat_ecode)
    );

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            error_count++;
            $display("error: %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // every helper starts and ends 2 ns after a rising edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic write_csr(input logic [13:0] num, input logic [31:0] mask,
                             input logic [31:0] value);
        csr_num    = num;
        csr_wmask  = mask;
        csr_wvalue = value;
        csr_we     = 1'b1;
        next_cycle();
        csr_we     = 1'b0;
    endtask

    // sampled at the falling edge in mid-cycle
    task automatic read_csr(input logic [13:0] num, output logic [31:0] data);
        csr_num = num;
        csr_we  = 1'b0;
        @(negedge clk);
        data = csr_rvalue;
        next_cycle();
    endtask

    task automatic pulse_exception(input logic [5:0] ecode, input logic [8:0] subcode,
                                   input logic [31:0] pc, input logic [31:0] vaddr);
        wb_ecode    = ecode;
        wb_esubcode = subcode;
        wb_pc       = pc;
        wb_vaddr    = vaddr;
        wb_ex       = 1'b1;
        next_cycle();
        wb_ex       = 1'b0;
    endtask

    task automatic wait_has_int(input logic level, input int max_cycles, input string name);
        int cycles;
        bit seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && (cycles < max_cycles))
        begin
            @(negedge clk);
            if (has_int === level)
                seen = 1'b1;
            next_cycle();
            cycles++;
        end
        if (!seen)
        begin
            timeout_count++;
            $display("timeout in %s: has_int never became %0d within %0d cycles",
                     name, level, max_cycles);
        end
    endtask

    task automatic wait_timer_flag(input logic level, input int max_cycles,
                                   input string name);
        logic [31:0] data;
        int          cycles;
        bit          seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && (cycles < max_cycles))
        begin
            read_csr(csr_pkg::estat, data);
            if (data[csr_pkg::estat_ti_bit] === level)
                seen = 1'b1;
            cycles++;
        end
        if (!seen)
        begin
            timeout_count++;
            $display("timeout in %s: timer bit of ESTAT never became %0d within %0d cycles",
                     name, level, max_cycles);
        end
    endtask

    task automatic test_reset_and_rw();
        logic [31:0] data;
        logic [31:0] mask;
        logic [31:0] value;
        int          idx;
        read_csr(csr_pkg::crmd, data);
        check_value("test_reset_and_rw crmd", 32'h0000_0008, data);
        read_csr(csr_pkg::tid, data);
        check_value("test_reset_and_rw tid", coreid_in, data);
        check_value("test_reset_and_rw has_int", 32'd0, 32'(has_int));
        // scratch words hold no reset value so fill them first
        for (int i = 0; i < 4; i++)
        begin
            save_model[i] = next_random();
            write_csr(14'(csr_pkg::save0 + i), 32'hffff_ffff, save_model[i]);
        end
        repeat (8)
        begin
            idx   = int'(next_random() & 32'd3);
            mask  = next_random();
            value = next_random();
            write_csr(14'(csr_pkg::save0 + idx), mask, value);
            save_model[idx] = (mask & value) | (~mask & save_model[idx]);
        end
        for (int i = 0; i < 4; i++)
        begin
            read_csr(14'(csr_pkg::save0 + i), data);
            check_value($sformatf("test_reset_and_rw save%0d", i), save_model[i], data);
        end
        value = next_random();
        write_csr(csr_pkg::eentry, 32'hffff_ffff, value);
        read_csr(csr_pkg::eentry, data);
        check_value("test_reset_and_rw eentry", value & 32'hffff_ffc0, data);
        check_value("test_reset_and_rw ex_entry", value & 32'hffff_ffc0, ex_entry);
    endtask

    task automatic run_exception(input string name, input logic [5:0] ecode,
                                 input logic [8:0] subcode, input logic [31:0] pc,
                                 input logic [31:0] vaddr, input logic [31:0] badv_expected);
        logic [31:0] data;
        // plv 3 with interrupts enabled before the exception
        write_csr(csr_pkg::crmd, 32'h0000_0007, 32'h0000_0007);
        pulse_exception(ecode, subcode, pc, vaddr);
        read_csr(csr_pkg::crmd, data);
        check_value({name, " crmd"}, 32'h0000_0008, data);
        read_csr(csr_pkg::prmd, data);
        check_value({name, " prmd"}, 32'h0000_0007, data);
        read_csr(csr_pkg::era, data);
        check_value({name, " era"}, pc, data);
        check_value({name, " ertn_pc"}, pc, ertn_pc);
        read_csr(csr_pkg::badv, data);
        check_value({name, " badv"}, badv_expected, data);
        check_value({name, " stat_ecode"}, 32'(ecode), 32'(stat_ecode));
        read_csr(csr_pkg::estat, data);
        check_value({name, " estat ecode"}, 32'(ecode), 32'(data[21:16]));
        check_value({name, " estat esubcode"}, 32'(subcode), 32'(data[30:22]));
    endtask

    task automatic test_exception_entry();
        run_exception("test_exception_entry ade", csr_pkg::ade, csr_pkg::esubcode_adef,
                      32'h1c00_0100, 32'h0000_2000, 32'h1c00_0100);
        run_exception("test_exception_entry ale", csr_pkg::ale, csr_pkg::esubcode_adem,
                      32'h1c00_0200, 32'h0000_3003, 32'h0000_3003);
        // sys leaves badv alone
        run_exception("test_exception_entry sys", csr_pkg::sys, 9'd0,
                      32'h1c00_0300, 32'h0000_4444, 32'h0000_3003);
    endtask

    task automatic test_return();
        logic [31:0] data;
        ertn_flush = 1'b1;
        next_cycle();
        ertn_flush = 1'b0;
        read_csr(csr_pkg::crmd, data);
        check_value("test_return crmd", 32'h0000_000f, data);
    endtask

    task automatic test_interrupts();
        logic [31:0] data;
        write_csr(csr_pkg::ecfg, 32'hffff_ffff, 32'h0);
        hw_int_in = 8'h01;
        next_cycle();
        next_cycle();
        check_value("test_interrupts masked line", 32'd0, 32'(has_int));
        write_csr(csr_pkg::ecfg, 32'h0000_0004, 32'h0000_0004);
        wait_has_int(1'b1, 10, "test_interrupts hardware line");
        read_csr(csr_pkg::estat, data);
        check_value("test_interrupts estat is", 32'h0000_0004, data & 32'h0000_1fff);
        write_csr(csr_pkg::crmd, 32'h0000_0004, 32'h0);
        check_value("test_interrupts ie cleared", 32'd0, 32'(has_int));
        hw_int_in = 8'h00;
        write_csr(csr_pkg::crmd, 32'h0000_0004, 32'h0000_0004);
        write_csr(csr_pkg::ecfg, 32'hffff_ffff, 32'h0000_0003);
        // software bit 0
        write_csr(csr_pkg::estat, 32'h0000_0003, 32'h0000_0001);
        wait_has_int(1'b1, 10, "test_interrupts software bit");
        write_csr(csr_pkg::estat, 32'h0000_0003, 32'h0);
        wait_has_int(1'b0, 10, "test_interrupts software clear");
        write_csr(csr_pkg::ecfg, 32'hffff_ffff, 32'h0);
    endtask

    task automatic test_timer();
        logic [31:0] first;
        logic [31:0] second;
        logic [31:0] data;
        // one-shot with initval 5
        write_csr(csr_pkg::tcfg, 32'hffff_ffff, (32'd5 << 2) | 32'h1);
        read_csr(csr_pkg::tval, first);
        read_csr(csr_pkg::tval, second);
        check_value("test_timer tval decreasing", 32'd1, 32'(second < first));
        wait_timer_flag(1'b1, 100, "test_timer one-shot");
        write_csr(csr_pkg::crmd, 32'h0000_0004, 32'h0000_0004);
        write_csr(csr_pkg::ecfg, 32'h0000_0800, 32'h0000_0800);
        wait_has_int(1'b1, 10, "test_timer has_int");
        write_csr(csr_pkg::ticlr, 32'h0000_0001, 32'h0000_0001);
        read_csr(csr_pkg::estat, data);
        check_value("test_timer ticlr", 32'd0, 32'(data[csr_pkg::estat_ti_bit]));
        check_value("test_timer has_int cleared", 32'd0, 32'(has_int));
        read_csr(csr_pkg::tval, data);
        check_value("test_timer one-shot stopped", 32'hffff_ffff, data);
        // periodic with initval 3
        write_csr(csr_pkg::tcfg, 32'hffff_ffff, (32'd3 << 2) | 32'h3);
        wait_timer_flag(1'b1, 100, "test_timer periodic first");
        write_csr(csr_pkg::ticlr, 32'h0000_0001, 32'h0000_0001);
        read_csr(csr_pkg::estat, data);
        check_value("test_timer periodic clear", 32'd0, 32'(data[csr_pkg::estat_ti_bit]));
        wait_timer_flag(1'b1, 100, "test_timer periodic again");
        write_csr(csr_pkg::tcfg, 32'hffff_ffff, 32'h0);
        write_csr(csr_pkg::ticlr, 32'h0000_0001, 32'h0000_0001);
        write_csr(csr_pkg::ecfg, 32'hffff_ffff, 32'h0);
    endtask

    initial
    begin
        error_count   = 0;
        timeout_count = 0;
        lcg_state     = 32'h898dd8fe;
        reset         = 1'b1;
        csr_num       = '0;
        csr_re        = 1'b0;
        csr_we        = 1'b0;
        csr_wmask     = '0;
        csr_wvalue    = '0;
        wb_ex         = 1'b0;
        wb_pc         = '0;
        wb_ecode      = '0;
        wb_esubcode   = '0;
        wb_vaddr      = '0;
        ertn_flush    = 1'b0;
        hw_int_in     = '0;
        ipi_int_in    = 1'b0;
        coreid_in     = 32'h0000_0003;
        repeat (10) @(posedge clk);
        #2;
        reset = 1'b0;
        test_reset_and_rw();
        test_exception_entry();
        test_return();
        test_interrupts();
        test_timer();
        $display("checks failed: %0d, timeouts: %0d", error_count, timeout_count);
        if ((error_count == 0) && (timeout_count == 0))
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

//--- project.f
hdl/csr_pkg.sv
hdl/csr_mode_regs.sv
hdl/csr_exc_regs.sv
hdl/csr_save_regs.sv
hdl/csr_timer.sv
hdl/csr_file.sv
test/tb_clock_gen.sv
test/csr_file_assertions.sv
test/tb_csr_file.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_csr_file
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(wildcard hdl/*.sv test/*.sv)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# status comes from the search for the pass line
run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -q "^Testbench passed$$"

clean:
	rm -rf $(BUILD_DIR)
